// File: verilog/cache_pkg.sv
// cache_pkg
// geometry, opcode encodings and entry types for the 4-way set-associative
// cache lookup pipeline, shared by the RTL and the testbench
package cache_pkg;

  // ==========================================================================
  // geometry
  // ==========================================================================
  parameter int NUM_WAYS     = 4;
  parameter int WAY_WIDTH    = 2;
  parameter int NUM_SETS     = 16;
  parameter int SET_WIDTH    = 4;
  parameter int WORD_WIDTH   = 32;
  parameter int WORDS_IN_CL  = 4;    // words per cache line
  parameter int OFFSET_WIDTH = 4;    // byte offset inside a line
  parameter int TAG_WIDTH    = 12;
  parameter int ADDR_WIDTH   = 20;   // {tag, set, offset}
  parameter int TQ_ID_WIDTH  = 4;

  parameter int WORD_OFF_MSB = 3;    // word select inside the byte offset
  parameter int WORD_OFF_LSB = 2;

  // ==========================================================================
  // encodings
  // ==========================================================================
  typedef enum logic [1:0] {RD_LU, WR_LU, FILL_LU} t_lu_op;
  typedef enum logic [1:0] {HIT, MISS, NO_RSP} t_lu_result;
  typedef enum logic {FILL_REQ_OP, DIRTY_EVICT_OP} t_fm_op;

  typedef logic [WORDS_IN_CL-1:0][WORD_WIDTH-1:0] t_cl;  // one cache line

  // one set of the tag array
  typedef struct packed {
    logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tags;
    logic [NUM_WAYS-1:0]                valid;
    logic [NUM_WAYS-1:0]                modified;
    logic [NUM_WAYS-1:0]                mru;
  } t_set_entry;

  // lookup payload carried through q2 and q3
  typedef struct packed {
    logic                    valid;
    t_lu_op                  op;
    logic [TQ_ID_WIDTH-1:0]  tq_id;
    logic [TAG_WIDTH-1:0]    tag;
    logic [SET_WIDTH-1:0]    set;
    logic [OFFSET_WIDTH-1:0] offset;
    logic [WORD_WIDTH-1:0]   data;         // write word
    t_cl                     cl_data;      // fill line
    logic [NUM_WAYS-1:0]     hit_vec;
    logic                    hit;
    logic [WAY_WIDTH-1:0]    way_enc;      // data array way, hit or victim
    logic                    dirty_evict;
    logic [TAG_WIDTH-1:0]    victim_tag;   // old tag of the evicted way
  } t_pipe_bus;

endpackage

// File: verilog/mem_if.sv
// mem_if
// read/write port between a pipeline stage and an array memory
`timescale 1ns/100ps

interface mem_if #(
  parameter type t_entry = logic,
  parameter int  DEPTH   = 16
) ();
  localparam int AW = $clog2(DEPTH);

  logic [AW-1:0] rd_addr;   // data returns next cycle
  t_entry        rd_data;
  logic          wr_en;
  logic [AW-1:0] wr_addr;
  t_entry        wr_data;

  modport user (output rd_addr, wr_en, wr_addr, wr_data, input rd_data);
  modport ram  (input rd_addr, wr_en, wr_addr, wr_data, output rd_data);

endinterface

// File: verilog/array_ram.sv
// array_ram
// entry array with a registered read port and one write port.
// a read of the address written in the same cycle returns the new entry,
// so back-to-back lookups to one set see each other's updates
`timescale 1ns/100ps

module array_ram #(
  parameter type t_entry = logic,
  parameter int  DEPTH   = 16
) (
  input logic clk,
  input logic rst_n,
  mem_if.ram  port
);

  t_entry mem [DEPTH];
  t_entry rd_q;            // registered read data

  // write port, whole array cleared on reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (port.wr_en) begin
      mem[port.wr_addr] <= port.wr_data;
    end
  end

  // read port with write-first bypass
  always_ff @(posedge clk) begin
    if (port.wr_en && (port.wr_addr == port.rd_addr)) begin
      rd_q <= port.wr_data;   // same-cycle hazard
    end else begin
      rd_q <= mem[port.rd_addr];
    end
  end

  assign port.rd_data = rd_q;

endmodule

// File: verilog/victim_select.sv
// victim_select
// picks the way a fill allocates into: first invalid way, else first way
// with a clear MRU bit. flags a dirty eviction when that way holds
// modified data
`timescale 1ns/100ps

module victim_select (
  input  logic [cache_pkg::NUM_WAYS-1:0]  valid,
  input  logic [cache_pkg::NUM_WAYS-1:0]  mru,
  input  logic [cache_pkg::NUM_WAYS-1:0]  modified,
  output logic [cache_pkg::NUM_WAYS-1:0]  victim,       // one-hot
  output logic [cache_pkg::WAY_WIDTH-1:0] victim_enc,
  output logic                            dirty
);
  import cache_pkg::*;

  logic free_found;    // some way is still invalid

  always_comb begin
    victim     = '0;
    victim_enc = '0;
    free_found = 1'b0;
    // lowest invalid way wins
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid[w]) begin
        victim     = NUM_WAYS'(1) << w;
        victim_enc = WAY_WIDTH'(w);
        free_found = 1'b1;
      end
    end
    // set full, fall back to lowest non-MRU way
    if (!free_found) begin
      for (int w = NUM_WAYS - 1; w >= 0; w--) begin
        if (!mru[w]) begin
          victim     = NUM_WAYS'(1) << w;
          victim_enc = WAY_WIDTH'(w);
        end
      end
    end
  end

  assign dirty = |(victim & valid & modified);   // old line must go to far memory

endmodule

// File: verilog/tag_stage.sv
// tag_stage
// q1 splits the lookup address and reads the tag array.
// q2 compares tags, picks a fill victim, writes the updated set back and
// issues the data array read at the hit or victim way
`timescale 1ns/100ps

module tag_stage (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   lu_valid,
  input  cache_pkg::t_lu_op                      lu_op,
  input  logic [cache_pkg::TQ_ID_WIDTH-1:0]      lu_tq_id,
  input  logic [cache_pkg::ADDR_WIDTH-1:0]       lu_address,
  input  logic [cache_pkg::WORD_WIDTH-1:0]       lu_data,
  input  cache_pkg::t_cl                         lu_cl_data,
  mem_if.user                                    tag_port,
  output logic [cache_pkg::SET_WIDTH+cache_pkg::WAY_WIDTH-1:0] cl_rd_addr,
  output cache_pkg::t_pipe_bus                   pipe_q2
);
  import cache_pkg::*;

  t_pipe_bus            pipe_q1;
  t_pipe_bus            lu_q2;         // lookup payload, no reset
  logic                 valid_q2;
  t_set_entry           set_rd;        // tag array entry of this set
  t_set_entry           set_upd;       // entry written back at end of q2
  logic [NUM_WAYS-1:0]  hit_vec;
  logic [WAY_WIDTH-1:0] hit_enc;
  logic [NUM_WAYS-1:0]  victim;
  logic [WAY_WIDTH-1:0] victim_enc;
  logic                 victim_dirty;
  logic [NUM_WAYS-1:0]  access_vec;    // way touched by this lookup
  logic                 is_fill;
  logic [WAY_WIDTH-1:0] way_enc;

  // ==========================================================================
  // q1  address split and tag read
  // ==========================================================================
  assign tag_port.rd_addr = lu_address[OFFSET_WIDTH +: SET_WIDTH];

  always_comb begin
    pipe_q1         = '0;
    pipe_q1.valid   = lu_valid;
    pipe_q1.op      = lu_op;
    pipe_q1.tq_id   = lu_tq_id;
    pipe_q1.tag     = lu_address[OFFSET_WIDTH+SET_WIDTH +: TAG_WIDTH];
    pipe_q1.set     = lu_address[OFFSET_WIDTH +: SET_WIDTH];
    pipe_q1.offset  = lu_address[OFFSET_WIDTH-1:0];
    pipe_q1.data    = lu_data;
    pipe_q1.cl_data = lu_cl_data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q2 <= 1'b0;
    end else begin
      valid_q2 <= lu_valid;
    end
  end

  always_ff @(posedge clk) begin
    lu_q2 <= pipe_q1;
  end

  // ==========================================================================
  // q2  tag compare, victim, set update, data read
  // ==========================================================================
  assign set_rd  = tag_port.rd_data;
  assign is_fill = valid_q2 && (lu_q2.op == FILL_LU);

  always_comb begin
    hit_vec = '0;
    hit_enc = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = valid_q2 && set_rd.valid[w] && (set_rd.tags[w] == lu_q2.tag);
      if (hit_vec[w]) begin
        hit_enc = WAY_WIDTH'(w);
      end
    end
  end

  victim_select u_victim (
    .valid      (set_rd.valid),
    .mru        (set_rd.mru),
    .modified   (set_rd.modified),
    .victim     (victim),
    .victim_enc (victim_enc),
    .dirty      (victim_dirty)
  );

  always_comb begin
    set_upd    = set_rd;                         // other ways untouched
    access_vec = '0;
    if (is_fill) begin
      access_vec               = victim;
      set_upd.tags[victim_enc] = lu_q2.tag;
      set_upd.valid            = set_rd.valid | victim;
      set_upd.modified         = set_rd.modified & ~victim;   // clean install
    end else if (|hit_vec) begin
      access_vec = hit_vec;
      if (lu_q2.op == WR_LU) begin
        set_upd.modified = set_rd.modified | hit_vec;
      end
    end
    set_upd.mru = set_rd.mru | access_vec;
    // all ways MRU: keep only the one just accessed
    if (&set_upd.mru) begin
      set_upd.mru = access_vec;
    end
  end

  // misses leave the set alone, fills and hits write it back
  assign tag_port.wr_en   = valid_q2 && (is_fill || (|hit_vec));
  assign tag_port.wr_addr = lu_q2.set;
  assign tag_port.wr_data = set_upd;

  assign way_enc    = is_fill ? victim_enc : hit_enc;
  assign cl_rd_addr = {lu_q2.set, way_enc};   // evicted line arrives in q3

  always_comb begin
    pipe_q2             = lu_q2;
    pipe_q2.valid       = valid_q2;
    pipe_q2.hit_vec     = hit_vec;
    pipe_q2.hit         = |hit_vec;
    pipe_q2.way_enc     = way_enc;
    pipe_q2.dirty_evict = is_fill && victim_dirty;
    pipe_q2.victim_tag  = set_rd.tags[victim_enc];
  end

endmodule

// File: verilog/data_stage.sv
// data_stage
// q3 of the lookup pipeline: builds the response, raises far-memory fill or
// dirty-evict requests and writes merged or filled lines to the data array
`timescale 1ns/100ps

module data_stage (
  input  logic                              clk,
  input  logic                              rst_n,
  input  cache_pkg::t_pipe_bus              pipe_q2,
  mem_if.user                               cl_port,
  output logic                              rsp_valid,
  output cache_pkg::t_lu_op                 rsp_op,
  output cache_pkg::t_lu_result             rsp_result,
  output logic [cache_pkg::TQ_ID_WIDTH-1:0] rsp_tq_id,
  output logic [cache_pkg::ADDR_WIDTH-1:0]  rsp_address,
  output cache_pkg::t_cl                    rsp_data,
  output logic                              fm_req_valid,
  output cache_pkg::t_fm_op                 fm_req_opcode,
  output logic [cache_pkg::ADDR_WIDTH-1:0]  fm_req_address,
  output logic [cache_pkg::TQ_ID_WIDTH-1:0] fm_req_tq_id,
  output cache_pkg::t_cl                    fm_req_data
);
  import cache_pkg::*;

  t_pipe_bus lu_q3;           // payload, no reset
  logic      valid_q3;
  t_cl       line_rd;         // line read at the hit or victim way
  t_cl       line_merged;     // line with the write word replaced
  logic      is_fill;
  logic      rd_hit;
  logic      wr_hit;
  logic      lu_miss;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q3 <= 1'b0;
    end else begin
      valid_q3 <= pipe_q2.valid;
    end
  end

  always_ff @(posedge clk) begin
    lu_q3 <= pipe_q2;
  end

  // ==========================================================================
  // q3  decode
  // ==========================================================================
  assign line_rd = cl_port.rd_data;
  assign is_fill = valid_q3 && (lu_q3.op == FILL_LU);
  assign rd_hit  = valid_q3 && (lu_q3.op == RD_LU) && lu_q3.hit;
  assign wr_hit  = valid_q3 && (lu_q3.op == WR_LU) && lu_q3.hit;
  assign lu_miss = valid_q3 && !is_fill && !lu_q3.hit;   // rd or wr miss

  // response to the TQ
  assign rsp_valid   = valid_q3;
  assign rsp_op      = lu_q3.op;
  assign rsp_result  = !valid_q3               ? NO_RSP :
                       (lu_q3.hit && !is_fill) ? HIT    : MISS;
  assign rsp_tq_id   = lu_q3.tq_id;
  assign rsp_address = {lu_q3.tag, lu_q3.set, lu_q3.offset};
  assign rsp_data    = is_fill ? lu_q3.cl_data :
                       rd_hit  ? line_rd       : '0;

  // far-memory request, a miss asks for the line, a dirty fill evicts
  always_comb begin
    fm_req_valid   = 1'b0;
    fm_req_opcode  = FILL_REQ_OP;
    fm_req_address = '0;
    fm_req_tq_id   = '0;
    fm_req_data    = '0;
    if (lu_miss) begin
      fm_req_valid   = 1'b1;
      fm_req_address = {lu_q3.tag, lu_q3.set, lu_q3.offset};
      fm_req_tq_id   = lu_q3.tq_id;
    end else if (is_fill && lu_q3.dirty_evict) begin
      fm_req_valid   = 1'b1;
      fm_req_opcode  = DIRTY_EVICT_OP;
      fm_req_address = {lu_q3.victim_tag, lu_q3.set, {OFFSET_WIDTH{1'b0}}};
      fm_req_tq_id   = lu_q3.tq_id;
      fm_req_data    = line_rd;   // old line of the victim way
    end
  end

  // data array write
  always_comb begin
    line_merged = line_rd;
    line_merged[lu_q3.offset[WORD_OFF_MSB:WORD_OFF_LSB]] = lu_q3.data;
  end

  assign cl_port.wr_en   = is_fill || wr_hit;
  assign cl_port.wr_addr = {lu_q3.set, lu_q3.way_enc};
  assign cl_port.wr_data = is_fill ? lu_q3.cl_data : line_merged;

endmodule

// File: verilog/cache_top.sv
// cache_top
// 4-way set-associative cache lookup pipeline, q1 to q3, with the tag array
// and data array held inside. one lookup per cycle, response two cycles later
`timescale 1ns/100ps

module cache_top (
  input  logic                              clk,
  input  logic                              rst_n,
  // lookup request
  input  logic                              lu_valid,
  input  cache_pkg::t_lu_op                 lu_op,
  input  logic [cache_pkg::TQ_ID_WIDTH-1:0] lu_tq_id,
  input  logic [cache_pkg::ADDR_WIDTH-1:0]  lu_address,
  input  logic [cache_pkg::WORD_WIDTH-1:0]  lu_data,
  input  cache_pkg::t_cl                    lu_cl_data,
  // lookup response
  output logic                              rsp_valid,
  output cache_pkg::t_lu_op                 rsp_op,
  output cache_pkg::t_lu_result             rsp_result,
  output logic [cache_pkg::TQ_ID_WIDTH-1:0] rsp_tq_id,
  output logic [cache_pkg::ADDR_WIDTH-1:0]  rsp_address,
  output cache_pkg::t_cl                    rsp_data,
  // far-memory request
  output logic                              fm_req_valid,
  output cache_pkg::t_fm_op                 fm_req_opcode,
  output logic [cache_pkg::ADDR_WIDTH-1:0]  fm_req_address,
  output logic [cache_pkg::TQ_ID_WIDTH-1:0] fm_req_tq_id,
  output cache_pkg::t_cl                    fm_req_data
);
  import cache_pkg::*;

  localparam int TAG_DEPTH = NUM_SETS;              // one entry per set
  localparam int CL_DEPTH  = NUM_SETS * NUM_WAYS;   // one line per set and way

  logic [SET_WIDTH+WAY_WIDTH-1:0] cl_rd_addr;   // data read, issued in q2

  mem_if #(.t_entry(t_set_entry), .DEPTH(TAG_DEPTH)) tag_port ();
  mem_if #(.t_entry(t_cl),        .DEPTH(CL_DEPTH))  cl_port ();

  t_pipe_bus pipe_q2;

  array_ram #(.t_entry(t_set_entry), .DEPTH(TAG_DEPTH)) u_tag_array (
    .clk   (clk),
    .rst_n (rst_n),
    .port  (tag_port.ram)
  );

  array_ram #(.t_entry(t_cl), .DEPTH(CL_DEPTH)) u_data_array (
    .clk   (clk),
    .rst_n (rst_n),
    .port  (cl_port.ram)
  );

  tag_stage u_tag_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .lu_valid   (lu_valid),
    .lu_op      (lu_op),
    .lu_tq_id   (lu_tq_id),
    .lu_address (lu_address),
    .lu_data    (lu_data),
    .lu_cl_data (lu_cl_data),
    .tag_port   (tag_port.user),
    .cl_rd_addr (cl_rd_addr),
    .pipe_q2    (pipe_q2)
  );

  assign cl_port.rd_addr = cl_rd_addr;   // read side of the data port comes from q2

  data_stage u_data_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .pipe_q2        (pipe_q2),
    .cl_port        (cl_port.user),
    .rsp_valid      (rsp_valid),
    .rsp_op         (rsp_op),
    .rsp_result     (rsp_result),
    .rsp_tq_id      (rsp_tq_id),
    .rsp_address    (rsp_address),
    .rsp_data       (rsp_data),
    .fm_req_valid   (fm_req_valid),
    .fm_req_opcode  (fm_req_opcode),
    .fm_req_address (fm_req_address),
    .fm_req_tq_id   (fm_req_tq_id),
    .fm_req_data    (fm_req_data)
  );

endmodule

// File: testbench/cache_tb.sv
// cache_tb
// directed tests for the 4-way cache lookup pipeline. keeps its own model of
// tags, valid, modified and MRU bits and lines, predicts each response
`timescale 1ns/100ps

module cache_tb;
  import cache_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int NUM_LOOKUPS  = 27;   // lookups issued over all tests
  localparam int MAX_CYCLES   = 2 * NUM_LOOKUPS + RESET_CYCLES;

  typedef struct {
    t_lu_op                  op;
    t_lu_result              result;
    logic [TQ_ID_WIDTH-1:0]  tq_id;
    logic [ADDR_WIDTH-1:0]   addr;
    t_cl                     data;
    logic                    fm_valid;
    t_fm_op                  fm_op;
    logic [ADDR_WIDTH-1:0]   fm_addr;
    t_cl                     fm_data;
    int                      issued;   // cycle the lookup was driven
  } t_expect;

  logic clk;
  logic rst_n;
  logic                    lu_valid;
  t_lu_op                  lu_op;
  logic [TQ_ID_WIDTH-1:0]  lu_tq_id;
  logic [ADDR_WIDTH-1:0]   lu_address;
  logic [WORD_WIDTH-1:0]   lu_data;
  t_cl                     lu_cl_data;
  logic                    rsp_valid;
  t_lu_op                  rsp_op;
  t_lu_result              rsp_result;
  logic [TQ_ID_WIDTH-1:0]  rsp_tq_id;
  logic [ADDR_WIDTH-1:0]   rsp_address;
  t_cl                     rsp_data;
  logic                    fm_req_valid;
  t_fm_op                  fm_req_opcode;
  logic [ADDR_WIDTH-1:0]   fm_req_address;
  logic [TQ_ID_WIDTH-1:0]  fm_req_tq_id;
  t_cl                     fm_req_data;

  // reference model of the arrays
  logic [TAG_WIDTH-1:0] m_tag   [NUM_SETS][NUM_WAYS];
  t_cl                  m_line  [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0]  m_valid [NUM_SETS];
  logic [NUM_WAYS-1:0]  m_mod   [NUM_SETS];
  logic [NUM_WAYS-1:0]  m_mru   [NUM_SETS];

  t_expect                exp_q[$];    // outstanding lookups, oldest first
  logic [TQ_ID_WIDTH-1:0] next_tq;
  logic [15:0]            lfsr;
  int    cycle = 0;
  int    errors = 0;
  int    errors_at_start;
  int    tests_run = 0;
  int    tests_failed = 0;
  string test_name;

  cache_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // cycle count and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout: run went past %0d cycles, the DUT stopped responding", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ==========================================================================
  // helpers
  // ==========================================================================
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic rand_word(output logic [WORD_WIDTH-1:0] w);
    w = '0;
    for (int i = 0; i < WORD_WIDTH; i++) begin
      lfsr = lfsr_step(lfsr);          // one step per bit taken
      w    = {w[WORD_WIDTH-2:0], lfsr[0]};
    end
  endtask

  task automatic rand_line(output t_cl l);
    logic [WORD_WIDTH-1:0] w;
    for (int i = 0; i < WORDS_IN_CL; i++) begin
      rand_word(w);
      l[i] = w;
    end
  endtask

  function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [TAG_WIDTH-1:0] tag,
      input logic [SET_WIDTH-1:0] set, input logic [OFFSET_WIDTH-1:0] off);
    return {tag, set, off};
  endfunction

  task automatic compare(input string what, input logic [127:0] expected,
                         input logic [127:0] actual);
    if (expected !== actual) begin
      $display("Error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic finish_test();
    if (errors == errors_at_start) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, errors - errors_at_start);
      tests_failed++;
    end
  endtask

  // ==========================================================================
  // model
  // ==========================================================================
  task automatic touch_mru(input int s, input int w);
    m_mru[s][w] = 1'b1;
    if (&m_mru[s]) begin
      m_mru[s] = NUM_WAYS'(1) << w;   // all set, keep only this way
    end
  endtask

  task automatic predict(input t_lu_op op, input logic [ADDR_WIDTH-1:0] addr,
                         input logic [WORD_WIDTH-1:0] wdata, input t_cl cl,
                         output t_expect e);
    int s;
    int way;
    int word;
    logic [TAG_WIDTH-1:0] tag;
    s    = int'(addr[OFFSET_WIDTH +: SET_WIDTH]);
    tag  = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    word = int'(addr[WORD_OFF_MSB:WORD_OFF_LSB]);
    e = '{op: op, result: MISS, tq_id: next_tq, addr: addr, data: '0, fm_valid: 1'b0,
          fm_op: FILL_REQ_OP, fm_addr: '0, fm_data: '0, issued: 0};
    next_tq = next_tq + 4'd1;
    way = -1;
    if (op == FILL_LU) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (way < 0 && !m_valid[s][w]) way = w;
      end
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (way < 0 && !m_mru[s][w]) way = w;
      end
      if (m_valid[s][way] && m_mod[s][way]) begin   // modified line leaves
        e.fm_valid = 1'b1;
        e.fm_op    = DIRTY_EVICT_OP;
        e.fm_addr  = make_addr(m_tag[s][way], addr[OFFSET_WIDTH +: SET_WIDTH], '0);
        e.fm_data  = m_line[s][way];
      end
      e.data         = cl;
      m_tag[s][way]  = tag;
      m_valid[s][way] = 1'b1;
      m_mod[s][way]  = 1'b0;                         // clean install
      m_line[s][way] = cl;
      touch_mru(s, way);
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (m_valid[s][w] && m_tag[s][w] == tag) way = w;
      end
      if (way < 0) begin
        e.fm_valid = 1'b1;   // miss asks far memory for the line
        e.fm_addr  = addr;
      end else begin
        e.result = HIT;
        if (op == RD_LU) begin
          e.data = m_line[s][way];
        end else begin
          m_line[s][way][word] = wdata;
          m_mod[s][way]        = 1'b1;
        end
        touch_mru(s, way);
      end
    end
  endtask

  // ==========================================================================
  // drive and sample
  // ==========================================================================
  task automatic sample_outputs();
    t_expect e;
    if (rsp_valid) begin
      if (exp_q.size() == 0) begin
        $display("%s: response seen with no lookup outstanding", test_name);
        errors++;
      end else begin
        e = exp_q.pop_front();
        compare("latency", 128'(e.issued + 2), 128'(cycle));
        compare("rsp_op", 128'(e.op), 128'(rsp_op));
        compare("rsp_result", 128'(e.result), 128'(rsp_result));
        compare("rsp_tq_id", 128'(e.tq_id), 128'(rsp_tq_id));
        compare("rsp_address", 128'(e.addr), 128'(rsp_address));
        compare("rsp_data", e.data, rsp_data);
        compare("fm_req_valid", 128'(e.fm_valid), 128'(fm_req_valid));
        if (e.fm_valid && fm_req_valid) begin
          compare("fm_req_opcode", 128'(e.fm_op), 128'(fm_req_opcode));
          compare("fm_req_address", 128'(e.fm_addr), 128'(fm_req_address));
          compare("fm_req_tq_id", 128'(e.tq_id), 128'(fm_req_tq_id));
          compare("fm_req_data", e.fm_data, fm_req_data);
        end
      end
    end else begin
      if (fm_req_valid) begin
        $display("%s: far-memory request raised without a response", test_name);
        errors++;
      end
      if (exp_q.size() > 0 && cycle > exp_q[0].issued + 2) begin
        $display("%s: lookup tq_id %0h got no response", test_name, exp_q[0].tq_id);
        errors++;
        void'(exp_q.pop_front());
      end
    end
  endtask

  // drives one lookup at the falling edge, runs one cycle
  task automatic issue(input t_lu_op op, input logic [ADDR_WIDTH-1:0] addr,
                       input logic [WORD_WIDTH-1:0] wdata, input t_cl cl);
    t_expect e;
    predict(op, addr, wdata, cl, e);
    e.issued   = cycle;
    exp_q.push_back(e);
    lu_valid   = 1'b1;
    lu_op      = op;
    lu_tq_id   = e.tq_id;
    lu_address = addr;
    lu_data    = wdata;
    lu_cl_data = cl;
    @(negedge clk);
    sample_outputs();
  endtask

  task automatic drain();
    lu_valid = 1'b0;
    while (exp_q.size() > 0) begin   // overdue entries get dropped in sample_outputs
      @(negedge clk);
      sample_outputs();
    end
  endtask

  task automatic read_line(input logic [ADDR_WIDTH-1:0] addr);
    issue(RD_LU, addr, '0, '0);
  endtask

  task automatic write_word(input logic [ADDR_WIDTH-1:0] addr);
    logic [WORD_WIDTH-1:0] w;
    rand_word(w);
    issue(WR_LU, addr, w, '0);
  endtask

  task automatic fill_line(input logic [ADDR_WIDTH-1:0] addr);
    t_cl cl;
    rand_line(cl);
    issue(FILL_LU, addr, '0, cl);
  endtask

  // ==========================================================================
  // tests
  // ==========================================================================
  initial begin
    rst_n      = 1'b0;
    lu_valid   = 1'b0;
    lu_op      = RD_LU;
    lu_tq_id   = '0;
    lu_address = '0;
    lu_data    = '0;
    lu_cl_data = '0;
    next_tq    = '0;
    lfsr       = 16'd87;
    for (int s = 0; s < NUM_SETS; s++) begin
      m_valid[s] = '0;
      m_mod[s]   = '0;
      m_mru[s]   = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_tag[s][w]  = '0;
        m_line[s][w] = '0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test("reset_and_miss");
    compare("rsp_valid after reset", 128'(1'b0), 128'(rsp_valid));
    compare("fm_req_valid after reset", 128'(1'b0), 128'(fm_req_valid));
    read_line(make_addr(12'h0a1, 4'h1, 4'h4));
    drain();
    finish_test();

    start_test("fill_then_read");
    fill_line(make_addr(12'h0a1, 4'h1, 4'h0));
    read_line(make_addr(12'h0a1, 4'h1, 4'h4));
    drain();
    finish_test();

    start_test("write_then_read");   // back to back, same line
    write_word(make_addr(12'h0a1, 4'h1, 4'h8));
    read_line(make_addr(12'h0a1, 4'h1, 4'h0));
    drain();
    finish_test();

    start_test("fill_set_replace");
    for (int i = 0; i < NUM_WAYS; i++) begin
      fill_line(make_addr(12'h010 + 12'(i), 4'h5, 4'h0));
    end
    drain();
    read_line(make_addr(12'h012, 4'h5, 4'h0));
    read_line(make_addr(12'h010, 4'h5, 4'h4));
    read_line(make_addr(12'h013, 4'h5, 4'h8));
    read_line(make_addr(12'h011, 4'h5, 4'hc));
    drain();
    fill_line(make_addr(12'h014, 4'h5, 4'h0));
    for (int i = 0; i <= NUM_WAYS; i++) begin
      read_line(make_addr(12'h010 + 12'(i), 4'h5, 4'h0));
    end
    drain();
    finish_test();

    start_test("dirty_evict");
    fill_line(make_addr(12'h020, 4'h9, 4'h0));
    fill_line(make_addr(12'h021, 4'h9, 4'h0));
    write_word(make_addr(12'h020, 4'h9, 4'hc));   // way 0 now modified
    fill_line(make_addr(12'h022, 4'h9, 4'h0));
    fill_line(make_addr(12'h023, 4'h9, 4'h0));
    fill_line(make_addr(12'h024, 4'h9, 4'h0));    // evicts the modified way
    fill_line(make_addr(12'h025, 4'h9, 4'h0));    // clean victim, no request
    read_line(make_addr(12'h020, 4'h9, 4'h0));
    drain();
    finish_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: cache.f
verilog/cache_pkg.sv
verilog/mem_if.sv
verilog/array_ram.sv
verilog/victim_select.sv
verilog/tag_stage.sv
verilog/data_stage.sv
verilog/cache_top.sv
testbench/cache_tb.sv

// File: Makefile
# Verilator build and run for the cache lookup pipeline testbench

TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps
TOP      = cache_tb
FILELIST = cache.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
